// ==== include/pixel_arb_macros.svh ====
//**********************************************************************
// Pixel readout sizing
// Block size, grid size and output queue depth of the 4x4 array
//**********************************************************************
`ifndef PIXEL_ARB_MACROS_SVH
`define PIXEL_ARB_MACROS_SVH

`define PIX_BLK_ROWS    2   // Pixel rows per block
`define PIX_BLK_COLS    2   // Pixel columns per block

`define PIX_GRID_ROWS   2   // Block rows in the array
`define PIX_GRID_COLS   2   // Block columns in the array

`define PIX_FIFO_DEPTH  4   // Output event queue entries

`endif

// ==== design/pixel_geom_pkg.sv ====
//**********************************************************************
// Pixel array geometry types
// Request matrices and index types for the array and its blocks
//**********************************************************************
`default_nettype none
`include "pixel_arb_macros.svh"

package pixel_geom_pkg;

    // One bit per pixel of the whole array, row-major
    typedef logic [`PIX_GRID_ROWS*`PIX_BLK_ROWS-1:0]
                  [`PIX_GRID_COLS*`PIX_BLK_COLS-1:0] pix_matrix_t;

    typedef logic [`PIX_BLK_ROWS-1:0][`PIX_BLK_COLS-1:0] blk_matrix_t;  // One block

    typedef logic [$clog2(`PIX_BLK_ROWS)-1:0] blk_row_t;   // Local row
    typedef logic [$clog2(`PIX_BLK_COLS)-1:0] blk_col_t;   // Local column

    // Block number, grid row-major
    typedef logic [$clog2(`PIX_GRID_ROWS*`PIX_GRID_COLS)-1:0] blk_id_t;

endpackage

`default_nettype wire

// ==== design/pixel_event_pkg.sv ====
//**********************************************************************
// Pixel event types
// Global address and the event word queued toward the consumer
//**********************************************************************
`default_nettype none
`include "pixel_arb_macros.svh"

package pixel_event_pkg;

    // Global row or column index over the full array
    typedef logic [$clog2(`PIX_GRID_ROWS*`PIX_BLK_ROWS)-1:0] pix_addr_t;

    typedef struct packed {
        pix_addr_t row;     // Global pixel row
        pix_addr_t col;     // Global pixel column
    } pix_event_t;

endpackage

`default_nettype wire

// ==== design/pixel_req_latch.sv ====
//**********************************************************************
// Pixel request latch
// Holds one sticky pending bit per pixel, set by a fire pulse and
// cleared by a grant; a fire in the same cycle as a grant wins
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "pixel_arb_macros.svh"

module pixel_req_latch
    import pixel_geom_pkg::*;
(
    input  wire logic        clk_i,        // System clock
    input  wire logic        reset_i,      // Async reset, active high
    input  wire pix_matrix_t fire_i,       // One-cycle fire pulses
    input  wire pix_matrix_t clear_i,      // Grants from the block arbiters
    output pix_matrix_t      pending_o     // Pending requests
);

    pix_matrix_t pending_q;    // Sticky request bits

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
            pending_q <= '0;
        else
            pending_q <= (pending_q & ~clear_i) | fire_i;  // Repeat fires merge
    end

    assign pending_o = pending_q;

endmodule

`default_nettype wire

// ==== design/rr_arbiter.sv ====
//**********************************************************************
// Round-robin arbiter
// Grants the first requester at or after a rotating priority pointer
// and moves the pointer past the winner when told to advance
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter #(
    parameter  int N  = 2,                          // Number of requesters
    localparam int IW = (N > 1) ? $clog2(N) : 1     // Index width
) (
    input  wire logic          clk_i,       // System clock
    input  wire logic          reset_i,     // Async reset, active high
    input  wire logic [N-1:0]  req_i,       // Requests
    input  wire logic          advance_i,   // Winner accepted, rotate
    output logic      [N-1:0]  gnt_o,       // One-hot grant
    output logic      [IW-1:0] idx_o,       // Index of the grant
    output logic               any_o        // Some request present
);

    logic [IW-1:0] ptr_q;      // Highest priority index

    always_comb
    begin : pick
        int  k;
        logic found;
        gnt_o = '0;
        idx_o = '0;
        found = 1'b0;
        for (int i = 0; i < N; i++)
        begin
            k = int'(ptr_q) + i;
            if (k >= N)
                k = k - N;                              // Wrap around
            if (!found && req_i[k])
            begin
                found    = 1'b1;
                gnt_o[k] = 1'b1;
                idx_o    = IW'(k);
            end
        end
        any_o = found;
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
            ptr_q <= '0;                                // Favour index 0
        else if (advance_i && any_o)
        begin
            if (idx_o == IW'(N - 1))
                ptr_q <= '0;
            else
                ptr_q <= idx_o + 1'b1;                  // One past the winner
        end
    end

endmodule

`default_nettype wire

// ==== design/pixel_block_arbiter.sv ====
//**********************************************************************
// Block arbiter
// Scans one pixel block row by row: picks a pending row, snapshots its
// column requests, then grants those columns one per accepted cycle.
// Releases the group when no row is left pending
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "pixel_arb_macros.svh"

module pixel_block_arbiter
    import pixel_geom_pkg::*;
(
    input  wire logic        clk_i,        // System clock
    input  wire logic        reset_i,      // Async reset, active high
    input  wire logic        enable_i,     // Block holds the scan
    input  wire logic        take_i,       // Grant this cycle is accepted
    input  wire blk_matrix_t req_i,        // Pending requests of the block
    output logic             req_o,        // Any request in the block
    output blk_matrix_t      gnt_o,        // One-hot pixel grant
    output logic             gnt_valid_o,  // Grant issued
    output blk_row_t         row_o,        // Local row of the grant
    output blk_col_t         col_o,        // Local column of the grant
    output logic             release_o     // Group release pulse
);

    typedef enum logic [1:0] {
        IDLE,
        ROW_PICK,
        COL_SCAN
    } state_t;

    state_t                    state_q, state_d;
    logic [`PIX_BLK_ROWS-1:0]  row_req;        // Row ORs
    logic [`PIX_BLK_ROWS-1:0]  row_gnt;
    blk_row_t                  row_idx;
    logic                      row_any;
    logic [`PIX_BLK_COLS-1:0]  snap_q, snap_d; // Columns still owed in the row
    logic [`PIX_BLK_COLS-1:0]  col_gnt;
    blk_col_t                  col_idx;
    logic                      col_any;
    logic [`PIX_BLK_COLS-1:0]  snap_left;      // Snapshot after this cycle's grant
    blk_row_t                  row_q;          // Row under scan

    assign req_o = |req_i;

    always_comb
    begin
        snap_d = '0;
        for (int i = 0; i < `PIX_BLK_ROWS; i++)
        begin
            row_req[i] = |req_i[i];
            if (row_gnt[i])
                snap_d = snap_d | req_i[i];          // Columns of the picked row
        end
    end

    rr_arbiter #(.N(`PIX_BLK_ROWS)) u_row_arb (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .req_i     (row_req),
        .advance_i (state_q == ROW_PICK),
        .gnt_o     (row_gnt),
        .idx_o     (row_idx),
        .any_o     (row_any)
    );

    rr_arbiter #(.N(`PIX_BLK_COLS)) u_col_arb (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .req_i     (snap_q),
        .advance_i (gnt_valid_o),
        .gnt_o     (col_gnt),
        .idx_o     (col_idx),
        .any_o     (col_any)
    );

    assign gnt_valid_o = (state_q == COL_SCAN) && col_any && take_i;  // Stall without room
    assign release_o   = (state_q == ROW_PICK) && !row_any;           // Nothing left here
    assign snap_left   = gnt_valid_o ? (snap_q & ~col_gnt) : snap_q;
    assign row_o       = row_q;
    assign col_o       = col_idx;

    always_comb
    begin
        for (int i = 0; i < `PIX_BLK_ROWS; i++)
            gnt_o[i] = (gnt_valid_o && row_q == blk_row_t'(i)) ? col_gnt : '0;
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            IDLE:
                if (enable_i)
                    state_d = ROW_PICK;
            ROW_PICK:
                if (!enable_i || !row_any)
                    state_d = IDLE;                  // Released or taken away
                else
                    state_d = COL_SCAN;
            COL_SCAN:
                if (!enable_i)
                    state_d = IDLE;
                else if (snap_left == '0)
                    state_d = ROW_PICK;              // Row done, pick the next
            default:
                state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            state_q <= IDLE;
            snap_q  <= '0;
            row_q   <= '0;
        end
        else
        begin
            state_q <= state_d;
            if (state_q == ROW_PICK && row_any)
            begin
                snap_q <= snap_d;                    // Later fires wait a visit
                row_q  <= row_idx;
            end
            else if (state_q == COL_SCAN)
                snap_q <= snap_left;
        end
    end

endmodule

`default_nettype wire

// ==== design/pixel_group_arbiter.sv ====
//**********************************************************************
// Group arbiter
// Passes the scan enable among blocks in round-robin order, holding it
// until the enabled block releases, and forms the global event address
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "pixel_arb_macros.svh"

module pixel_group_arbiter
    import pixel_geom_pkg::*;
    import pixel_event_pkg::*;
#(
    localparam int NB = `PIX_GRID_ROWS * `PIX_GRID_COLS     // Block count
) (
    input  wire logic              clk_i,           // System clock
    input  wire logic              reset_i,         // Async reset, active high
    input  wire logic     [NB-1:0] blk_req_i,       // Block has requests
    input  wire logic     [NB-1:0] blk_gnt_valid_i, // Block grants now
    input  wire blk_row_t [NB-1:0] blk_row_i,       // Local grant rows
    input  wire blk_col_t [NB-1:0] blk_col_i,       // Local grant columns
    input  wire logic     [NB-1:0] blk_release_i,   // Block release pulses
    input  wire logic              fifo_room_i,     // Output queue not full
    output logic          [NB-1:0] blk_enable_o,    // One-hot scan enable
    output logic                   take_o,          // Grants are accepted
    output logic                   push_valid_o,    // Event to queue
    output pix_event_t             push_event_o     // Global event address
);

    logic [NB-1:0] blk_gnt;
    blk_id_t       blk_idx;
    logic          blk_any;
    logic          hand_off;       // Enable is free this cycle
    blk_id_t       cur_q;          // Enabled block

    assign hand_off = !(|blk_enable_o) || (|(blk_release_i & blk_enable_o));

    rr_arbiter #(.N(NB)) u_blk_arb (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .req_i     (blk_req_i),
        .advance_i (hand_off),
        .gnt_o     (blk_gnt),
        .idx_o     (blk_idx),
        .any_o     (blk_any)
    );

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            blk_enable_o <= '0;
            cur_q        <= '0;
        end
        else if (hand_off)
        begin
            blk_enable_o <= blk_any ? blk_gnt : '0;    // Next requesting block
            cur_q        <= blk_idx;
        end
    end

    assign take_o       = fifo_room_i;                 // Queue never refuses
    assign push_valid_o = |(blk_gnt_valid_i & blk_enable_o);

    // Block grid position scaled by block size plus local offset
    always_comb
    begin : addr
        int br;
        int bc;
        br = int'(cur_q) / `PIX_GRID_COLS;
        bc = int'(cur_q) % `PIX_GRID_COLS;
        push_event_o.row = pix_addr_t'(br * `PIX_BLK_ROWS + int'(blk_row_i[cur_q]));
        push_event_o.col = pix_addr_t'(bc * `PIX_BLK_COLS + int'(blk_col_i[cur_q]));
    end

endmodule

`default_nettype wire

// ==== design/event_out_fifo.sv ====
//**********************************************************************
// Output event FIFO
// Circular buffer with a count; delivers events over valid/ready
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module event_out_fifo
    import pixel_event_pkg::*;
#(
    parameter  int DEPTH = 4,                       // Entries
    localparam int PW    = $clog2(DEPTH),           // Pointer width
    localparam int CW    = $clog2(DEPTH + 1)        // Count width
) (
    input  wire logic       clk_i,         // System clock
    input  wire logic       reset_i,       // Async reset, active high
    input  wire logic       push_i,        // Write an event
    input  wire pix_event_t push_data_i,   // Event to write
    output logic            room_o,        // Not full
    output logic            valid_o,       // Head is valid
    input  wire logic       ready_i,       // Consumer takes the head
    output pix_event_t      data_o         // Head event
);

    pix_event_t      mem [DEPTH];
    logic [PW-1:0]   wr_ptr_q, rd_ptr_q;
    logic [CW-1:0]   count_q;
    logic            wr_en, rd_en;

    assign room_o  = count_q != CW'(DEPTH);
    assign valid_o = count_q != '0;
    assign data_o  = mem[rd_ptr_q];                // Stable until popped
    assign wr_en   = push_i && room_o;
    assign rd_en   = valid_o && ready_i;

    always_ff @(posedge clk_i)
    begin
        if (wr_en)
            mem[wr_ptr_q] <= push_data_i;
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr_q <= (wr_ptr_q == PW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            if (rd_en)
                rd_ptr_q <= (rd_ptr_q == PW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            if (wr_en && !rd_en)
                count_q <= count_q + 1'b1;
            else if (rd_en && !wr_en)
                count_q <= count_q - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== design/pixel_readout_top.sv ====
//**********************************************************************
// Pixel readout top
// Request latch, four block arbiters, group arbiter and output FIFO
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "pixel_arb_macros.svh"

module pixel_readout_top
    import pixel_geom_pkg::*;
    import pixel_event_pkg::*;
(
    input  wire logic        clk_i,         // System clock
    input  wire logic        reset_i,       // Async reset, active high
    input  wire pix_matrix_t pix_fire_i,    // Pixel fire pulses
    output logic             evt_valid_o,   // Event available
    output pix_event_t       evt_o,         // Global pixel address
    input  wire logic        evt_ready_i    // Consumer ready
);

    localparam int NB = `PIX_GRID_ROWS * `PIX_GRID_COLS;

    pix_matrix_t          pending, clear;
    blk_matrix_t [NB-1:0] blk_pend, blk_gnt;
    logic        [NB-1:0] blk_req, blk_gnt_valid, blk_release, blk_enable;
    blk_row_t    [NB-1:0] blk_row;
    blk_col_t    [NB-1:0] blk_col;
    logic                 take, push_valid;
    logic                 fifo_room;        // Output queue not full
    pix_event_t           push_event;

    pixel_req_latch u_latch (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .fire_i    (pix_fire_i),
        .clear_i   (clear),
        .pending_o (pending)
    );

    for (genvar b = 0; b < NB; b++)
    begin : g_blk
        localparam int BR = b / `PIX_GRID_COLS;   // Block grid row
        localparam int BC = b % `PIX_GRID_COLS;   // Block grid column

        for (genvar r = 0; r < `PIX_BLK_ROWS; r++)
        begin : g_row
            assign blk_pend[b][r] =
                pending[BR*`PIX_BLK_ROWS + r][BC*`PIX_BLK_COLS +: `PIX_BLK_COLS];
            assign clear[BR*`PIX_BLK_ROWS + r][BC*`PIX_BLK_COLS +: `PIX_BLK_COLS] =
                blk_gnt[b][r];
        end

        pixel_block_arbiter u_blk (
            .clk_i       (clk_i),
            .reset_i     (reset_i),
            .enable_i    (blk_enable[b]),
            .take_i      (take),
            .req_i       (blk_pend[b]),
            .req_o       (blk_req[b]),
            .gnt_o       (blk_gnt[b]),
            .gnt_valid_o (blk_gnt_valid[b]),
            .row_o       (blk_row[b]),
            .col_o       (blk_col[b]),
            .release_o   (blk_release[b])
        );
    end

    pixel_group_arbiter u_group (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .blk_req_i       (blk_req),
        .blk_gnt_valid_i (blk_gnt_valid),
        .blk_row_i       (blk_row),
        .blk_col_i       (blk_col),
        .blk_release_i   (blk_release),
        .fifo_room_i     (fifo_room),
        .blk_enable_o    (blk_enable),
        .take_o          (take),
        .push_valid_o    (push_valid),
        .push_event_o    (push_event)
    );

    event_out_fifo #(.DEPTH(`PIX_FIFO_DEPTH)) u_fifo (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .push_i      (push_valid),
        .push_data_i (push_event),
        .room_o      (fifo_room),
        .valid_o     (evt_valid_o),
        .ready_i     (evt_ready_i),
        .data_o      (evt_o)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
//**********************************************************************
// Testbench clock and reset generator
// 20 ns clock; reset held for 5 cycles at start and on each restart
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,    // Clock period
    parameter int RESET_CYCLES = 5      // Rising edges under reset
) (
    input  wire logic restart_i,        // Rising edge requests a new reset
    output logic      clk_o,            // Testbench clock
    output logic      reset_o           // Active high reset
);

    initial
    begin
        clk_o = 1'b0;
        forever
            #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial
    begin
        reset_o = 1'b1;
        forever
        begin
            repeat (RESET_CYCLES) @(posedge clk_o);
            #1 reset_o = 1'b0;          // Release just after the edge
            @(posedge restart_i);
            reset_o = 1'b1;             // Async assert
        end
    end

endmodule

`default_nettype wire

// ==== testbench/pixel_readout_tb.sv ====
//**********************************************************************
// Pixel readout testbench
// Drives fire pulses and consumer ready into the readout top, tracks
// outstanding pixels in a model and checks every output transfer
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "pixel_arb_macros.svh"

module pixel_readout_tb
    import pixel_geom_pkg::*;
    import pixel_event_pkg::*;
();

    localparam int ARR_COLS = `PIX_GRID_COLS * `PIX_BLK_COLS;
    localparam int NPIX     = `PIX_GRID_ROWS * `PIX_BLK_ROWS * ARR_COLS;

    logic              clk, reset, restart;
    pix_matrix_t       pix_fire;
    logic              evt_ready, evt_valid;
    pix_event_t        evt;
    logic [NPIX-1:0]   model_pend;             // Fired and not yet delivered
    pix_event_t        obs_q[$];               // Delivered events in order
    logic [31:0]       rng_state;
    int                error_count, check_count;
    string             test_name;
    logic              stalled;                // Valid without ready last cycle
    pix_event_t        stalled_evt;

    tb_clock_gen u_clk (.restart_i(restart), .clk_o(clk), .reset_o(reset));

    pixel_readout_top UUT (
        .clk_i       (clk),
        .reset_i     (reset),
        .pix_fire_i  (pix_fire),
        .evt_valid_o (evt_valid),
        .evt_o       (evt),
        .evt_ready_i (evt_ready)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Outputs sampled mid-cycle, ahead of the edge that transfers
    always @(negedge clk)
    begin : monitor
        int idx;
        if (reset)
            stalled = 1'b0;
        else
        begin
            if (stalled)
            begin
                check_count++;
                if (!evt_valid || evt !== stalled_evt)
                begin
                    $display("** Error [%s]: expected held event %h, actual %h valid %b",
                             test_name, stalled_evt, evt, evt_valid);
                    error_count++;
                end
            end
            stalled     = evt_valid && !evt_ready;
            stalled_evt = evt;
            if (evt_valid && evt_ready)
            begin
                idx = int'(evt.row) * ARR_COLS + int'(evt.col);
                check_count++;
                if (!model_pend[idx])
                begin
                    $display("[%s] Event for row %0d col %0d, but that pixel is not pending",
                             test_name, evt.row, evt.col);
                    error_count++;
                end
                model_pend[idx] = 1'b0;        // Delivered once
                obs_q.push_back(evt);
            end
        end
    end

    task automatic step();
        @(posedge clk);
        #2;                                    // Drive slot after the edge
    endtask

    task automatic compare_event(input pix_event_t exp, input pix_event_t act);
        check_count++;
        if (act !== exp)
        begin
            $display("** Error [%s]: expected row %0d col %0d, actual row %0d col %0d",
                     test_name, exp.row, exp.col, act.row, act.col);
            error_count++;
        end
    endtask

    task automatic expect_valid_low();
        check_count++;
        if (evt_valid !== 1'b0)
        begin
            $display("** Error [%s]: expected evt_valid_o 0, actual %b", test_name, evt_valid);
            error_count++;
        end
    endtask

    task automatic await_events(input int count, input int limit);
        int n;
        n = 0;
        while (obs_q.size() < count && n < limit)
        begin
            step();
            n++;
        end
        if (obs_q.size() < count)
        begin
            $display("[%s] Timed out after %0d cycles, %0d of %0d events seen",
                     test_name, limit, obs_q.size(), count);
            error_count++;
        end
    endtask

    task automatic watch_quiet(input int count, input int cycles);
        repeat (cycles)
            step();
        check_count++;
        if (obs_q.size() != count)
        begin
            $display("[%s] Expected %0d events in total, but %0d arrived",
                     test_name, count, obs_q.size());
            error_count++;
        end
    endtask

    task automatic restart_dut();
        int n;
        step();
        pix_fire = '0;
        evt_ready = 1'b1;
        restart = 1'b1;
        step();
        restart = 1'b0;
        n = 0;
        while (reset && n < 20)
        begin
            @(posedge clk);
            n++;
        end
        if (reset)
        begin
            $display("[%s] Reset did not release within 20 cycles", test_name);
            error_count++;
        end
        #2;
        model_pend = '0;                       // DUT starts empty
        obs_q.delete();
    endtask

    task automatic reset_behaviour();
        int n;
        test_name = "reset";
        n = 0;
        step();                                // First look after the first edge
        while (reset && n < 20)
        begin
            expect_valid_low();                // Low under reset
            step();
            n++;
        end
        if (reset)
        begin
            $display("[%s] Reset still asserted after 20 cycles", test_name);
            error_count++;
        end
        repeat (50)
        begin
            expect_valid_low();                // No fires, no events
            step();
        end
    endtask

    task automatic single_event();
        int         idx;
        pix_event_t exp;
        test_name = "single";
        restart_dut();
        rng_state = xorshift32(rng_state);
        idx = int'(rng_state % NPIX);
        exp.row = pix_addr_t'(idx / ARR_COLS);
        exp.col = pix_addr_t'(idx % ARR_COLS);
        pix_fire = pix_matrix_t'(NPIX'(1) << idx);
        model_pend[idx] = 1'b1;
        step();
        pix_fire = '0;
        await_events(1, 40);
        if (obs_q.size() > 0)
            compare_event(exp, obs_q[0]);
        watch_quiet(1, 50);
    endtask

    task automatic ordered_burst();
        int         k;
        pix_event_t exp;
        test_name = "burst";
        restart_dut();
        pix_fire = '1;
        model_pend = '1;
        step();
        pix_fire = '1;                         // Repeat pulse merges
        step();
        pix_fire = '0;
        await_events(NPIX, 200);
        k = 0;
        for (int b = 0; b < `PIX_GRID_ROWS * `PIX_GRID_COLS; b++)
            for (int lr = 0; lr < `PIX_BLK_ROWS; lr++)
                for (int lc = 0; lc < `PIX_BLK_COLS; lc++)
                begin
                    exp.row = pix_addr_t'((b / `PIX_GRID_COLS) * `PIX_BLK_ROWS + lr);
                    exp.col = pix_addr_t'((b % `PIX_GRID_COLS) * `PIX_BLK_COLS + lc);
                    if (k < obs_q.size())
                        compare_event(exp, obs_q[k]);
                    k++;
                end
        watch_quiet(NPIX, 30);
    endtask

    task automatic random_traffic(input string name, input logic throttle, input int cycles);
        int              n;
        logic [NPIX-1:0] fire_vec;
        test_name = name;
        restart_dut();
        repeat (cycles)
        begin
            fire_vec = '0;
            for (int p = 0; p < NPIX; p++)
            begin
                rng_state = xorshift32(rng_state);
                if (rng_state[3:0] == 4'd0 && !model_pend[p])
                    fire_vec[p] = 1'b1;        // Only pixels not outstanding
            end
            rng_state = xorshift32(rng_state);
            evt_ready = throttle ? rng_state[7] : 1'b1;
            pix_fire = pix_matrix_t'(fire_vec);
            model_pend = model_pend | fire_vec;
            step();
        end
        pix_fire = '0;
        evt_ready = 1'b1;
        n = 0;
        while (model_pend != '0 && n < 200)
        begin
            step();
            n++;
        end
        check_count++;
        if (model_pend != '0)
        begin
            $display("[%s] Pending set not empty after drain, left %h", test_name, model_pend);
            error_count++;
        end
    endtask

    initial
    begin
        pix_fire    = '0;
        evt_ready   = 1'b1;
        restart     = 1'b0;
        model_pend  = '0;
        stalled     = 1'b0;
        stalled_evt = '0;
        rng_state   = 32'd87604;
        error_count = 0;
        check_count = 0;
        test_name   = "init";
        reset_behaviour();
        single_event();
        ordered_burst();
        random_traffic("random", 1'b0, 400);
        random_traffic("backpressure", 1'b1, 400);
        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
design/pixel_geom_pkg.sv
design/pixel_event_pkg.sv
design/pixel_req_latch.sv
design/rr_arbiter.sv
design/pixel_block_arbiter.sv
design/pixel_group_arbiter.sv
design/event_out_fifo.sv
design/pixel_readout_top.sv
testbench/tb_clock_gen.sv
testbench/pixel_readout_tb.sv

// ==== Bender.yml ====
package:
  name: pixel_readout

export_include_dirs:
  - include

sources:
  - files:
      - design/pixel_geom_pkg.sv
      - design/pixel_event_pkg.sv
      - design/pixel_req_latch.sv
      - design/rr_arbiter.sv
      - design/pixel_block_arbiter.sv
      - design/pixel_group_arbiter.sv
      - design/event_out_fifo.sv
      - design/pixel_readout_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/pixel_readout_tb.sv
